// ==== list.f ====
rtl/rapcore_pkg.sv
rtl/spi_target.sv
rtl/spi_state_machine.sv
rtl/move_buffer.sv
rtl/step_generator.sv
rtl/rapcore.sv
dv/tb_rapcore_asserts.sv
dv/tb_rapcore.sv

// ==== Bender.yml ====
package:
  name: rapcore

sources:
  - files:
      - rtl/rapcore_pkg.sv
      - rtl/spi_target.sv
      - rtl/spi_state_machine.sv
      - rtl/move_buffer.sv
      - rtl/step_generator.sv
      - rtl/rapcore.sv
  - target: test
    files:
      - dv/tb_rapcore_asserts.sv
      - dv/tb_rapcore.sv

// ==== dv/tb_rapcore.sv ====
`timescale 1ns/10ps

module tb_rapcore import rapcore_pkg::*; ();

  localparam int motor_count    = 2;
  localparam int buffer_depth   = 4;
  localparam int half_clk       = 20;
  localparam int max_hp         = 7;     // Longest SCK half-period in CLK cycles
  localparam int n_random       = 12;
  localparam int long_dur       = 12000; // Outlasts several frames
  localparam int halt_dur       = 3000;
  localparam int n_frames       = 40;
  localparam int drain_cycles   = (buffer_depth + 1) * (long_dur + 8);  // Longest backlog
  localparam int frame_cycles   =
    (1 + motor_count) * word_bits * (2 * max_hp + 1) + 3 * max_hp + 2;
  localparam int move_cycles    =
    (n_random + 4) * 64 + (buffer_depth + 1) * long_dur + halt_dur;
  localparam int timeout_cycles = 2 * (n_frames * frame_cycles + move_cycles) + 1000;

  logic                   CLK;
  logic                   resetn;
  logic                   SCK;
  logic                   CS;
  logic                   COPI;
  logic                   CIPO;
  logic                   HALT;
  logic                   BUFFER_DTR;
  logic                   MOVE_DONE;
  logic [motor_count-1:0] STEPOUTPUT;
  logic [motor_count-1:0] DIROUTPUT;
  logic [motor_count-1:0] ENOUTPUT;

  logic [31:0]            lfsr_state;
  logic [word_bits-1:0]   frame_buf [max_motors+1];
  logic [31:0]            model_acc [motor_count];
  logic [motor_count-1:0] model_mask;
  int                     exp_steps_q [$];   // motor_count entries per move
  logic [motor_count-1:0] exp_dir_q [$];
  int                     step_cnt [motor_count];
  int                     pushed_count;
  int                     done_count;
  int                     halted_count;
  bit                     run_checks;
  string                  test_name;

  rapcore #(
    .motor_count(motor_count), .move_duration_bits(16), .buffer_depth(buffer_depth)
  ) DUT (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .HALT(HALT), .BUFFER_DTR(BUFFER_DTR), .MOVE_DONE(MOVE_DONE),
    .STEPOUTPUT(STEPOUTPUT), .DIROUTPUT(DIROUTPUT), .ENOUTPUT(ENOUTPUT)
  );

  initial begin
    CLK = 1'b0;
    forever #(half_clk) CLK = ~CLK;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[31]};
    end
    return v;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_steps(input string what, input int expected, input int actual);
    if (expected != actual)
      stop_run($sformatf("Error %s %s: expected %0d, actual %0d",
                         test_name, what, expected, actual));
  endtask

  task automatic check_dir(input string what, input logic [motor_count-1:0] expected,
                           input logic [motor_count-1:0] actual);
    if (expected !== actual)
      stop_run($sformatf("Error %s %s: expected %b, actual %b",
                         test_name, what, expected, actual));
  endtask

  task automatic check_enable(input string what, input logic [motor_count-1:0] expected,
                              input logic [motor_count-1:0] actual);
    if (expected !== actual)
      stop_run($sformatf("Error %s %s: expected %b, actual %b",
                         test_name, what, expected, actual));
  endtask

  task automatic check_status(input string what, input status_t expected,
                              input status_t actual);
    if (expected !== actual)
      stop_run($sformatf("Error %s %s: expected %h, actual %h",
                         test_name, what, expected, actual));
  endtask

  function automatic status_t expect_status(input logic active, input int fill);
    status_t s;
    s        = '0;
    s.enable = max_motors'(model_mask);
    s.active = active;
    s.fill   = fill_bits'(fill);
    return s;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  // Mode 0 frame of n_words from frame_buf, returns the first word read back
  task automatic spi_frame(input int n_words, output status_t first_word);
    int                   hp;
    logic [word_bits-1:0] rd;
    hp = 4 + int'(take_bits(2));
    rd = '0;
    @(posedge CLK);
    CS <= 1'b0;
    wait_cycles(hp);
    for (int w = 0; w < n_words; w++) begin
      for (int b = word_bits - 1; b >= 0; b--) begin
        COPI <= frame_buf[w][b];
        wait_cycles(hp);
        @(negedge CLK);
        if (w == 0) rd = {rd[word_bits-2:0], CIPO};  // Sampled ahead of the rising edge
        @(posedge CLK);
        SCK <= 1'b1;
        wait_cycles(hp);
        SCK <= 1'b0;
      end
    end
    wait_cycles(hp);
    CS   <= 1'b1;
    COPI <= 1'b0;
    wait_cycles(hp);
    first_word = status_t'(rd);
  endtask

  task automatic read_status(output status_t s);
    frame_buf[0] = '0;  // Opcode 0 is ignored
    spi_frame(1, s);
  endtask

  task automatic send_move(input int dur, input bit accepted);
    logic [rate_bits-1:0]   rate [motor_count];
    logic [motor_count-1:0] dir;
    logic [32:0]            sum;
    int                     cnt;
    status_t                reply_word;
    frame_buf[0] = {8'(op_move), 8'h00, 16'(dur)};
    for (int m = 0; m < motor_count; m++) begin
      rate[m]        = rate_bits'(take_bits(30));
      dir[m]         = 1'(take_bits(1));
      frame_buf[1+m] = {dir[m], rate[m]};
    end
    if (accepted) begin
      for (int m = 0; m < motor_count; m++) begin
        cnt = 0;
        for (int t = 0; t < dur; t++) begin
          sum          = {1'b0, model_acc[m]} + {2'b00, rate[m]};
          cnt         += int'(sum[32]);  // Carry out is one step
          model_acc[m] = sum[31:0];
        end
        exp_steps_q.push_back(cnt);
      end
      exp_dir_q.push_back(dir);
      pushed_count++;
    end
    spi_frame(1 + motor_count, reply_word);
  endtask

  // Gives up after the longest backlog so a missing MOVE_DONE shows in the count
  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_dir_q.size() != 0 && waited < drain_cycles) begin
      @(negedge CLK);
      waited++;
    end
    wait_cycles(4);
  endtask

  task automatic wait_dtr();
    @(negedge CLK);
    while (!BUFFER_DTR) @(negedge CLK);
  endtask

  // Step and MOVE_DONE monitor
  always @(negedge CLK) begin
    if (HALT) begin
      halted_count += exp_dir_q.size();
      exp_dir_q.delete();
      exp_steps_q.delete();
      foreach (step_cnt[i]) step_cnt[i] = 0;
    end else if (run_checks) begin
      foreach (step_cnt[i]) step_cnt[i] += int'(STEPOUTPUT[i]);
      if (STEPOUTPUT != '0) begin
        if (exp_dir_q.size() == 0) stop_run("A step pulse came with no move pending");
        else check_dir("DIROUTPUT", exp_dir_q[0], DIROUTPUT);
      end
      if (MOVE_DONE) begin
        if (exp_dir_q.size() == 0) begin
          stop_run("MOVE_DONE came with no move pending");
        end else begin
          foreach (step_cnt[i]) begin
            check_steps($sformatf("steps of motor %0d", i), exp_steps_q.pop_front(),
                        step_cnt[i]);
            step_cnt[i] = 0;
          end
          void'(exp_dir_q.pop_front());
          done_count++;
        end
      end
    end
  end

  initial begin
    wait_cycles(timeout_cycles);
    stop_run("Timeout: the tests did not finish in the expected time");
  end

  initial begin
    status_t                status_rd;
    logic [motor_count-1:0] new_mask;
    lfsr_state   = 32'h7d541f23;
    resetn       = 1'b0;
    SCK          = 1'b0;
    CS           = 1'b1;
    COPI         = 1'b0;
    HALT         = 1'b0;
    run_checks   = 1'b0;
    model_mask   = '0;
    pushed_count = 0;
    done_count   = 0;
    halted_count = 0;
    foreach (model_acc[i]) model_acc[i] = '0;
    foreach (step_cnt[i]) step_cnt[i] = 0;

    test_name = "reset";
    wait_cycles(2);
    resetn <= 1'b1;
    @(negedge CLK);
    while (!BUFFER_DTR) begin
      if ({STEPOUTPUT, DIROUTPUT, ENOUTPUT, MOVE_DONE, CIPO} !== '0)
        stop_run("An output was active while the core was in reset");
      else @(negedge CLK);
    end
    run_checks = 1'b1;
    read_status(status_rd);
    check_status("status after reset", expect_status(1'b0, 0), status_rd);

    test_name = "enable";
    repeat (4) begin
      new_mask     = motor_count'(take_bits(motor_count));
      frame_buf[0] = {8'(op_enable), 24'(new_mask)};
      spi_frame(1, status_rd);
      check_status("status before enable", expect_status(1'b0, 0), status_rd);
      model_mask = new_mask;
      check_enable("ENOUTPUT", model_mask, ENOUTPUT);
      read_status(status_rd);
      check_status("status after enable", expect_status(1'b0, 0), status_rd);
    end

    test_name = "random moves";
    repeat (n_random) begin
      wait_dtr();
      send_move(int'(take_bits(6)), 1'b1);
    end
    wait_idle();
    check_steps("MOVE_DONE count", pushed_count - halted_count, done_count);

    test_name = "buffer full";
    for (int k = 0; k <= buffer_depth; k++) send_move(long_dur, 1'b1);  // First one pops
    @(negedge CLK);
    if (BUFFER_DTR !== 1'b0) stop_run("BUFFER_DTR stayed high with a full buffer");
    read_status(status_rd);
    check_status("status when full", expect_status(1'b1, buffer_depth), status_rd);
    send_move(long_dur, 1'b0);
    read_status(status_rd);
    check_status("status after dropped frame", expect_status(1'b1, buffer_depth), status_rd);
    wait_idle();
    check_steps("MOVE_DONE count", pushed_count - halted_count, done_count);

    test_name = "bad frames";
    frame_buf[0] = {8'(op_move), 8'h00, 16'd40};
    spi_frame(motor_count, status_rd);  // Last rate word never sent
    frame_buf[0] = {8'h5A, 8'h00, 16'd40};
    spi_frame(1 + motor_count, status_rd);
    wait_cycles(8);
    read_status(status_rd);
    check_status("status after bad frames", expect_status(1'b0, 0), status_rd);
    send_move(int'(take_bits(6)), 1'b1);
    wait_idle();
    check_steps("MOVE_DONE count", pushed_count - halted_count, done_count);

    test_name = "halt";
    send_move(halt_dur, 1'b1);
    send_move(int'(take_bits(6)), 1'b1);
    wait_cycles(100);
    HALT <= 1'b1;
    foreach (model_acc[i]) model_acc[i] = '0;
    wait_cycles(3);
    HALT <= 1'b0;
    wait_cycles(2);
    check_steps("moves dropped by HALT", 2, halted_count);
    read_status(status_rd);
    check_status("status after HALT", expect_status(1'b0, 0), status_rd);
    send_move(int'(take_bits(6)) + 1, 1'b1);
    wait_idle();
    check_steps("MOVE_DONE count", pushed_count - halted_count, done_count);

    if (DUT.u_asserts.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      stop_run("A bound assertion reported a failure");
    end
  end

endmodule

// ==== dv/tb_rapcore_asserts.sv ====
`timescale 1ns/10ps

module tb_rapcore_asserts import rapcore_pkg::*; #(
  parameter int motor_count  = 2,
  parameter int buffer_depth = 4
) (
  input logic                   CLK,
  input logic                   core_resetn,
  input logic                   halt,
  input logic [fill_bits-1:0]   fill,
  input logic                   buffer_dtr,
  input logic                   move_done,
  input logic [motor_count-1:0] step
);

  int fail_count = 0;  // Read back at the end of the run

  // Registers settle one cycle into reset
  no_output_in_reset: assert property (@(posedge CLK)
    (core_resetn === 1'b0 && $past(core_resetn) === 1'b0) |->
      (step == '0 && !move_done && !buffer_dtr))
    else begin
      $error("Step, MOVE_DONE or BUFFER_DTR active during internal reset");
      fail_count++;
    end

  no_adjacent_steps: assert property (@(posedge CLK) disable iff (core_resetn !== 1'b1)
    (step & $past(step)) == '0)
    else begin
      $error("Step pulses in two consecutive cycles");
      fail_count++;
    end

  // Room for a move exactly while the fill level is below the depth
  dtr_matches_fill: assert property (@(posedge CLK) disable iff (core_resetn !== 1'b1)
    buffer_dtr == (int'(fill) < buffer_depth))
    else begin
      $error("BUFFER_DTR does not match the move buffer fill level");
      fail_count++;
    end

  // Steps stay off through the cycle after HALT drops
  no_step_in_halt: assert property (@(posedge CLK) disable iff (core_resetn !== 1'b1)
    (halt || $past(halt)) |-> step == '0)
    else begin
      $error("Step pulse while HALT is high or just after it");
      fail_count++;
    end

endmodule

bind rapcore tb_rapcore_asserts #(
  .motor_count(motor_count), .buffer_depth(buffer_depth)
) u_asserts (
  .CLK(CLK), .core_resetn(core_resetn), .halt(HALT), .fill(fill),
  .buffer_dtr(BUFFER_DTR), .move_done(MOVE_DONE), .step(STEPOUTPUT)
);

// ==== rtl/rapcore.sv ====
`timescale 1ns/10ps

module rapcore import rapcore_pkg::*; #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 16,
  parameter int buffer_depth       = 4
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   SCK,
  input  logic                   CS,
  input  logic                   COPI,
  output logic                   CIPO,
  input  logic                   HALT,
  output logic                   BUFFER_DTR,
  output logic                   MOVE_DONE,
  output logic [motor_count-1:0] STEPOUTPUT,
  output logic [motor_count-1:0] DIROUTPUT,
  output logic [motor_count-1:0] ENOUTPUT
);

  logic [7:0]           reset_cnt;
  logic                 core_resetn;  // Stretched internal reset
  spi_word_t            rx;
  logic                 frame_start;
  logic                 frame_end;
  status_t              reply;
  logic                 push;
  move_t                push_move;
  move_t                head;
  logic                 empty;
  logic                 full;
  logic [fill_bits-1:0] fill;
  logic                 pop;
  logic                 move_active;

  // Release 255 cycles after resetn goes high
  always_ff @(posedge CLK) begin
    if (!resetn) reset_cnt <= '0;
    else if (!core_resetn) reset_cnt <= reset_cnt + 1'b1;
  end

  assign core_resetn = &reset_cnt;
  assign BUFFER_DTR  = core_resetn & ~full;

  spi_target u_spi (
    .CLK(CLK), .resetn(core_resetn),
    .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .reply(reply), .rx(rx),
    .frame_start(frame_start), .frame_end(frame_end)
  );

  spi_state_machine #(
    .motor_count(motor_count), .move_duration_bits(move_duration_bits)
  ) u_spifsm (
    .CLK(CLK), .resetn(core_resetn), .rx(rx),
    .frame_start(frame_start), .frame_end(frame_end),
    .fill(fill), .move_active(move_active),
    .push(push), .move(push_move), .enable(ENOUTPUT), .reply(reply)
  );

  move_buffer #(.buffer_depth(buffer_depth)) u_buffer (
    .CLK(CLK), .resetn(core_resetn), .flush(HALT),
    .push(push), .move_in(push_move), .pop(pop),
    .head(head), .empty(empty), .full(full), .fill(fill)
  );

  step_generator #(
    .motor_count(motor_count), .move_duration_bits(move_duration_bits)
  ) u_stepgen (
    .CLK(CLK), .resetn(core_resetn), .abort(HALT),
    .empty(empty), .head(head), .pop(pop), .move_active(move_active),
    .step(STEPOUTPUT), .dir(DIROUTPUT), .move_done(MOVE_DONE)
  );

endmodule

// ==== rtl/step_generator.sv ====
`timescale 1ns/10ps

module step_generator import rapcore_pkg::*; #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 16
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   abort,
  input  logic                   empty,
  input  move_t                  head,
  output logic                   pop,
  output logic                   move_active,
  output logic [motor_count-1:0] step,
  output logic [motor_count-1:0] dir,
  output logic                   move_done
);

  typedef enum logic [1:0] {
    st_idle,
    st_pop,
    st_run
  } state_t;

  state_t                        state;
  move_t                         cur;         // Move being executed
  logic [move_duration_bits-1:0] ticks_left;
  logic [31:0]                   acc [motor_count];
  logic [32:0]                   sum [motor_count];
  logic [motor_count-1:0]        step_q;
  logic                          done_q;
  logic                          ticking;

  assign ticking     = state == st_run;
  assign pop         = state == st_pop;  // Only entered with a non-empty buffer
  assign move_active = state != st_idle;

  always_comb begin
    for (int i = 0; i < motor_count; i++) begin
      sum[i] = {1'b0, acc[i]} + {2'b0, cur.rate[i]};
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn || abort) begin
      state      <= st_idle;
      cur        <= '0;
      ticks_left <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        st_idle: if (!empty) state <= st_pop;
        st_pop: begin
          cur        <= head;
          ticks_left <= head.duration[move_duration_bits-1:0];
          if (head.duration[move_duration_bits-1:0] == '0) begin
            done_q <= 1'b1;  // Zero length completes at once
            state  <= st_idle;
          end else begin
            state <= st_run;
          end
        end
        st_run: begin
          ticks_left <= ticks_left - 1'b1;
          if (ticks_left == move_duration_bits'(1)) begin
            done_q <= 1'b1;  // Lines up with last step pulse
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Accumulators carry over between moves
  always_ff @(posedge CLK) begin
    if (!resetn || abort) begin
      step_q <= '0;
      for (int i = 0; i < motor_count; i++) acc[i] <= '0;
    end else begin
      for (int i = 0; i < motor_count; i++) begin
        step_q[i] <= ticking & sum[i][32];  // Carry out is a step
        if (ticking) acc[i] <= sum[i][31:0];
      end
    end
  end

  assign step      = step_q & {motor_count{~abort}};
  assign move_done = done_q & ~abort;
  assign dir       = cur.dir[motor_count-1:0];

endmodule

// ==== rtl/move_buffer.sv ====
`timescale 1ns/10ps

module move_buffer import rapcore_pkg::*; #(
  parameter int buffer_depth = 4
) (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 flush,
  input  logic                 push,
  input  move_t                move_in,
  input  logic                 pop,
  output move_t                head,
  output logic                 empty,
  output logic                 full,
  output logic [fill_bits-1:0] fill
);

  localparam int ptr_bits = $clog2(buffer_depth);

  move_t                mem [buffer_depth];
  logic [ptr_bits-1:0]  wr_ptr;
  logic [ptr_bits-1:0]  rd_ptr;
  logic [fill_bits-1:0] count;
  logic                 do_push;
  logic                 do_pop;

  assign full    = count == fill_bits'(buffer_depth);
  assign empty   = count == '0;
  assign do_push = push & ~full;  // Push into a full buffer is dropped
  assign do_pop  = pop & ~empty;

  always_ff @(posedge CLK) begin
    if (!resetn || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + fill_bits'(do_push) - fill_bits'(do_pop);
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) mem[wr_ptr] <= move_in;
  end

  assign head = mem[rd_ptr];
  assign fill = count;

endmodule

// ==== rtl/spi_state_machine.sv ====
`timescale 1ns/10ps

module spi_state_machine import rapcore_pkg::*; #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 16
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  spi_word_t              rx,
  input  logic                   frame_start,
  input  logic                   frame_end,
  input  logic [fill_bits-1:0]   fill,
  input  logic                   move_active,
  output logic                   push,
  output move_t                  move,
  output logic [motor_count-1:0] enable,
  output status_t                reply
);

  localparam int idx_bits = $clog2(max_motors);

  typedef enum logic [1:0] {
    st_idle,
    st_header,
    st_rates,
    st_ignore
  } state_t;

  state_t                state;
  logic [idx_bits-1:0]   word_idx;   // Rate word being collected
  logic [max_motors-1:0] enable_q;
  logic                  push_q;
  move_t                 move_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state    <= st_idle;
      word_idx <= '0;
      enable_q <= '0;
      push_q   <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (frame_start) begin
        state <= st_header;
      end else if (frame_end) begin
        state <= st_idle;  // Unfinished move is discarded
      end else if (rx.valid) begin
        case (state)
          st_header: begin
            case (opcode_t'(rx.data[word_bits-1 -: op_bits]))
              op_move: begin
                word_idx <= '0;
                state    <= st_rates;
              end
              op_enable: begin
                enable_q <= max_motors'(rx.data[motor_count-1:0]);
                state    <= st_ignore;
              end
              default: state <= st_ignore;  // Unknown opcode
            endcase
          end
          st_rates: begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == idx_bits'(motor_count - 1)) begin
              push_q <= 1'b1;  // Last rate word
              state  <= st_ignore;
            end
          end
          default: state <= state;
        endcase
      end
    end
  end

  // Record under construction
  always_ff @(posedge CLK) begin
    if (rx.valid && state == st_header) begin
      move_q          <= '0;
      move_q.duration <= dur_bits'(rx.data[move_duration_bits-1:0]);
    end else if (rx.valid && state == st_rates) begin
      move_q.rate[word_idx] <= rx.data[rate_bits-1:0];
      move_q.dir[word_idx]  <= rx.data[word_bits-1];  // Bit 31 is direction
    end
  end

  assign push   = push_q;
  assign move   = move_q;
  assign enable = enable_q[motor_count-1:0];

  always_comb begin
    reply        = '0;
    reply.enable = enable_q;
    reply.active = move_active;
    reply.fill   = fill;
  end

endmodule

// ==== rtl/spi_target.sv ====
`timescale 1ns/10ps

module spi_target import rapcore_pkg::*; (
  input  logic      CLK,
  input  logic      resetn,
  input  logic      SCK,
  input  logic      CS,
  input  logic      COPI,
  output logic      CIPO,
  input  status_t   reply,
  output spi_word_t rx,
  output logic      frame_start,
  output logic      frame_end
);

  localparam int cnt_bits = $clog2(word_bits);

  logic [2:0]           sck_r;      // Two sync stages plus edge history
  logic [2:0]           cs_r;
  logic [1:0]           copi_r;
  logic                 sck_rise;
  logic                 sck_fall;
  logic [cnt_bits-1:0]  bit_cnt;
  logic [word_bits-1:0] shift_in;
  logic [word_bits-1:0] shift_out;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_r  <= '0;
      cs_r   <= '1;  // CS idles high
      copi_r <= '0;
    end else begin
      sck_r  <= {sck_r[1:0], SCK};
      cs_r   <= {cs_r[1:0], CS};
      copi_r <= {copi_r[0], COPI};
    end
  end

  assign sck_rise    = sck_r[1] & ~sck_r[2] & ~cs_r[1];
  assign sck_fall    = ~sck_r[1] & sck_r[2] & ~cs_r[1];
  assign frame_start = cs_r[2] & ~cs_r[1];
  assign frame_end   = ~cs_r[2] & cs_r[1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt   <= '0;
      shift_in  <= '0;
      shift_out <= '0;
      rx        <= '0;
    end else begin
      rx.valid <= 1'b0;
      if (cs_r[1]) begin
        bit_cnt <= '0;  // Partial word is lost
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 1'b1;
        shift_in <= {shift_in[word_bits-2:0], copi_r[1]};
        if (bit_cnt == cnt_bits'(word_bits - 1)) begin
          rx.valid <= 1'b1;
          rx.data  <= {shift_in[word_bits-2:0], copi_r[1]};
        end
      end
      // Mode 0 so the MSB must sit on CIPO before the first rising edge
      if (frame_start) begin
        shift_out <= reply;
      end else if (sck_fall) begin
        if (bit_cnt == '0) shift_out <= reply;  // Word boundary
        else shift_out <= shift_out << 1;
      end
    end
  end

  assign CIPO = shift_out[word_bits-1];

endmodule

// ==== rtl/rapcore_pkg.sv ====
package rapcore_pkg;

  localparam int word_bits  = 32;
  localparam int max_motors = 8;
  localparam int dur_bits   = 16;  // Width of move_t.duration
  localparam int rate_bits  = 31;  // Rate magnitude below 2^31
  localparam int fill_bits  = 8;
  localparam int op_bits    = 8;

  // Frame opcodes live in header bits 31..24
  typedef enum logic [op_bits-1:0] {
    op_move   = 8'h01,
    op_enable = 8'h0A
  } opcode_t;

  typedef struct packed {
    logic [dur_bits-1:0]                  duration;  // Ticks
    logic [max_motors-1:0][rate_bits-1:0] rate;
    logic [max_motors-1:0]                dir;
  } move_t;

  typedef struct packed {
    logic [max_motors-1:0]                         enable;    // Bits 31..24
    logic [word_bits-max_motors-fill_bits-2:0]     reserved;
    logic                                          active;    // Bit 8
    logic [fill_bits-1:0]                          fill;      // Bits 7..0
  } status_t;

  typedef struct packed {
    logic                 valid;  // One cycle per word
    logic [word_bits-1:0] data;
  } spi_word_t;

endpackage
